// ==== common/fragmentPkg.sv ====
//////////////////////////////
// Shared types and constants for the texturing subsystem
// Coordinates are signed 1.15, channels are 8-bit unsigned
// Texture is fixed at 16x16 texels, no filtering
//////////////////////////////
package fragmentPkg;

    //////////////////////////////
    // Sizes and latencies
    //////////////////////////////
    localparam int subPixelWidth = 8;
    localparam int texSize = 16;

    // Texel fetch, from index register to returned data
    localparam int texelLatency = 6;
    // Two register stages in the combiner
    localparam int envLatency = 2;
    // Decode stage plus fetch plus combiner
    localparam int pipeLatency = 1 + texelLatency + envLatency;

    //////////////////////////////
    // Host address map, word addresses
    //////////////////////////////
    localparam logic [11:0] adrControl = 12'h000;
    localparam logic [11:0] adrEnvColor = 12'h001;
    // Texels at 0x100..0x1FF, index = t*16 + s
    localparam logic [11:0] adrTexBase = 12'h100;

    //////////////////////////////
    // Data types
    //////////////////////////////
    typedef struct packed {
        logic [subPixelWidth-1:0] r;
        logic [subPixelWidth-1:0] g;
        logic [subPixelWidth-1:0] b;
        logic [subPixelWidth-1:0] a;
    } pixel_t;

    typedef struct packed {
        logic valid;
        pixel_t color;
        logic signed [15:0] s;
        logic signed [15:0] t;
    } fragment_t;

    // Codes 5..7 fall back to REPLACE
    typedef enum logic [2:0] {
        REPLACE = 3'd0,
        MODULATE = 3'd1,
        DECAL = 3'd2,
        BLEND = 3'd3,
        ADD = 3'd4
    } texEnvFunc_t;

    // Clamp bits: 1 clamps to edge, 0 repeats
    typedef struct packed {
        texEnvFunc_t envFunc;
        logic clampS;
        logic clampT;
        pixel_t envColor;
    } conf_t;

    // Wishbone classic, host to slave
    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        logic [11:0] adr;
        logic [31:0] dat;
    } wbReq_t;

    // Wishbone classic, slave to host
    typedef struct packed {
        logic [31:0] dat;
        logic ack;
    } wbRsp_t;

endpackage

// ==== design/valueDelay.sv ====
//////////////////////////////
// Fixed-depth register chain, depth must be at least 1
// Reset clears every stage
//////////////////////////////
`timescale 1ns/1ps

module valueDelay
#(
    parameter type payload_t = logic,
    parameter int depth = 1
)
(
    input logic aclk,
    input logic rst,
    input payload_t in,
    output payload_t out
);

    payload_t chain [depth];

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            // Flags in the chain come up low
            for (int i = 0; i < depth; i++)
                chain[i] <= '0;
        end
        else
        begin
            chain[0] <= in;
            for (int i = 1; i < depth; i++)
                chain[i] <= chain[i-1];
        end
    end

    // Last stage
    assign out = chain[depth-1];

endmodule

// ==== design/textureMemory.sv ====
//////////////////////////////
// 256-entry texel store, one write port, one read port
// Read latency is texelLatency, fully pipelined
// Same-index write and read return the old texel
// No readback to the host
//////////////////////////////
`timescale 1ns/1ps

module textureMemory
    import fragmentPkg::*;
(
    input logic aclk,
    input logic we,
    input logic [7:0] wrIndex,
    input pixel_t wrData,
    input logic [7:0] rdIndex,
    output pixel_t rdData
);

    localparam int entries = texSize * texSize;
    // One cycle for the array read, rest in the output pipe
    localparam int pipeDepth = texelLatency - 1;

    pixel_t mem [entries];
    pixel_t readReg;
    pixel_t outPipe [pipeDepth];

    //////////////////////////////
    // Array access
    //////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (we)
            mem[wrIndex] <= wrData;
        // Nonblocking, so a colliding write is not seen here
        readReg <= mem[rdIndex];
    end

    //////////////////////////////
    // Output pipe
    //////////////////////////////
    // Stands in for the external texture buffer latency
    always_ff @(posedge aclk)
    begin
        outPipe[0] <= readReg;
        for (int i = 1; i < pipeDepth; i++)
            outPipe[i] <= outPipe[i-1];
    end

    assign rdData = outPipe[pipeDepth-1];

    // Controls known from the second edge on, once reset has hit the index register
    ctrlKnown: assert property (@(posedge aclk) ##1 !$isunknown({we, rdIndex}))
        else $error("textureMemory: unknown write enable or read index");

endmodule

// ==== design/confRegs.sv ====
//////////////////////////////
// Wishbone classic slave, single-cycle ack
// Host must hold cyc and stb until ack
// Texel addresses are write-only and read zero
// Unmapped addresses ack, ignore writes, read zero
//////////////////////////////
`timescale 1ns/1ps

module confRegs
    import fragmentPkg::*;
(
    input logic aclk,
    input logic rst,
    input wbReq_t wbIn,
    output wbRsp_t wbOut,
    output conf_t conf,
    output logic texWe,
    output logic [7:0] texIndex,
    output pixel_t texData
);

    logic ack;
    logic access;
    logic isTex;
    logic [31:0] readMux;
    logic [31:0] rdData;

    // New request, skipping the cycle where ack is already up
    assign access = wbIn.cyc && wbIn.stb && !ack;

    // Texel window 0x100..0x1FF
    assign isTex = wbIn.adr[11:8] == adrTexBase[11:8];

    //////////////////////////////
    // Texture write path
    //////////////////////////////
    // Lands in memory on the same edge that raises ack
    assign texWe = access && wbIn.we && isTex;
    assign texIndex = wbIn.adr[7:0];
    assign texData = wbIn.dat;

    //////////////////////////////
    // Handshake
    //////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
            ack <= 1'b0;
        else
            ack <= access;
    end

    //////////////////////////////
    // Configuration registers
    //////////////////////////////
    always_ff @(posedge aclk)
    begin
        if (rst)
            // REPLACE, repeat on both axes, black env color
            conf <= '0;
        else if (access && wbIn.we)
        begin
            case (wbIn.adr)
                adrControl:
                begin
                    conf.envFunc <= texEnvFunc_t'(wbIn.dat[2:0]);
                    conf.clampS <= wbIn.dat[3];
                    conf.clampT <= wbIn.dat[4];
                end
                adrEnvColor:
                    conf.envColor <= wbIn.dat;
                default:
                    ;
            endcase
        end
    end

    //////////////////////////////
    // Read data
    //////////////////////////////
    always_comb
    begin
        readMux = '0;
        case (wbIn.adr)
            adrControl:
                readMux = {27'd0, conf.clampT, conf.clampS, conf.envFunc};
            adrEnvColor:
                readMux = conf.envColor;
            default:
                ;
        endcase
    end

    // Captured with ack, held valid while ack is high
    always_ff @(posedge aclk)
    begin
        if (access)
            rdData <= readMux;
    end

    assign wbOut = '{dat: rdData, ack: ack};

endmodule

// ==== texEnv/texEnv.sv ====
//////////////////////////////
// Texture environment combiner, latency envLatency
// REPLACE, MODULATE, DECAL, BLEND, ADD
// Products are truncated by a shift of 8
// Unknown function codes act as REPLACE
//////////////////////////////
`timescale 1ns/1ps

module texEnv
    import fragmentPkg::*;
(
    input logic aclk,
    input logic rst,
    input texEnvFunc_t func,
    input pixel_t texSrcColor,
    input pixel_t primaryColor,
    input pixel_t envColor,
    output pixel_t color
);

    localparam int prodWidth = 2 * subPixelWidth;
    localparam int hiBit = prodWidth - 1;

    // Index 3 is red, index 0 is alpha
    typedef logic [3:0][subPixelWidth-1:0] channels_t;

    channels_t tCh;
    channels_t pCh;
    channels_t eCh;
    channels_t tInv;

    assign tCh = texSrcColor;
    assign pCh = primaryColor;
    assign eCh = envColor;
    // 255 - x, as a plain bit inversion
    assign tInv = ~tCh;

    //////////////////////////////
    // Stage 1
    //////////////////////////////
    logic [3:0][prodWidth-1:0] modProd;
    logic [3:1][prodWidth-1:0] decalSum;
    logic [3:1][prodWidth-1:0] blendSum;
    // One carry bit for saturation
    logic [3:1][subPixelWidth:0] addSum;
    pixel_t s1Texel;
    logic [subPixelWidth-1:0] s1PrimAlpha;
    texEnvFunc_t s1Func;

    // Every function computed, picked in stage 2
    always_ff @(posedge aclk)
    begin
        // P*T, all four channels
        for (int i = 0; i < 4; i++)
            modProd[i] <= pCh[i] * tCh[i];
        for (int i = 1; i < 4; i++)
        begin
            // T*Ta + P*(255-Ta), never above 255*255
            decalSum[i] <= tCh[i] * tCh[0] + pCh[i] * tInv[0];
            // P*(255-T) + E*T
            blendSum[i] <= pCh[i] * tInv[i] + eCh[i] * tCh[i];
            addSum[i] <= pCh[i] + tCh[i];
        end
        s1Texel <= texSrcColor;
        s1PrimAlpha <= pCh[0];
    end

    // Function follows its data
    always_ff @(posedge aclk)
    begin
        if (rst)
            s1Func <= REPLACE;
        else
            s1Func <= func;
    end

    //////////////////////////////
    // Stage 2
    //////////////////////////////
    channels_t result;

    always_comb
    begin
        // REPLACE and unmapped codes
        result = s1Texel;
        case (s1Func)
            MODULATE:
            begin
                for (int i = 0; i < 4; i++)
                    result[i] = modProd[i][hiBit -: subPixelWidth];
            end
            DECAL:
            begin
                for (int i = 1; i < 4; i++)
                    result[i] = decalSum[i][hiBit -: subPixelWidth];
                // Alpha stays primary
                result[0] = s1PrimAlpha;
            end
            BLEND:
            begin
                for (int i = 1; i < 4; i++)
                    result[i] = blendSum[i][hiBit -: subPixelWidth];
                result[0] = modProd[0][hiBit -: subPixelWidth];
            end
            ADD:
            begin
                // Clip at full scale on carry
                for (int i = 1; i < 4; i++)
                    result[i] = addSum[i][subPixelWidth] ? '1 : addSum[i][subPixelWidth-1:0];
                result[0] = modProd[0][hiBit -: subPixelWidth];
            end
            default:
                ;
        endcase
    end

    always_ff @(posedge aclk)
    begin
        color <= result;
    end

endmodule

// ==== fragmentPipeline/fragmentPipeline.sv ====
//////////////////////////////
// One fragment per clock, latency pipeLatency, no stall
// Config sampled at decode, in-flight fragments keep theirs
// Positive 1.15 values stay below 1.0, so the upper clamp
// never has to act
//////////////////////////////
`timescale 1ns/1ps

module fragmentPipeline
    import fragmentPkg::*;
(
    input logic aclk,
    input logic rst,
    input conf_t conf,
    input fragment_t fragIn,
    output logic [7:0] texelIndex,
    input pixel_t texel,
    output logic outValid,
    output pixel_t outColor
);

    // Index bits per axis, taken from the top of the fraction
    localparam int idxBits = $clog2(texSize);

    // Negative goes to zero in clamp mode, raw bits in repeat mode
    function automatic logic [15:0] clampCoord(input logic [15:0] coord, input logic clamp);
        logic [15:0] result;
        result = coord;
        if (clamp && coord[15])
            result = '0;
        return result;
    endfunction

    //////////////////////////////
    // Decode
    //////////////////////////////
    logic [15:0] sCoord;
    logic [15:0] tCoord;
    logic decValid;
    pixel_t decColor;
    conf_t decConf;

    assign sCoord = clampCoord(fragIn.s, conf.clampS);
    assign tCoord = clampCoord(fragIn.t, conf.clampT);

    always_ff @(posedge aclk)
    begin
        if (rst)
        begin
            decValid <= 1'b0;
            texelIndex <= '0;
        end
        else
        begin
            decValid <= fragIn.valid;
            // Row major, t*16 + s
            texelIndex <= {tCoord[14 -: idxBits], sCoord[14 -: idxBits]};
        end
    end

    // Color and config ride along with the index
    always_ff @(posedge aclk)
    begin
        decColor <= fragIn.color;
        decConf <= conf;
    end

    //////////////////////////////
    // Latency matching
    //////////////////////////////
    pixel_t exColor;
    conf_t exConf;

    // Primary color waits for the texel fetch
    valueDelay #(.payload_t(pixel_t), .depth(texelLatency)) colorDelay (
        .aclk(aclk),
        .rst(rst),
        .in(decColor),
        .out(exColor)
    );

    // Function and env color, kept per fragment
    valueDelay #(.payload_t(conf_t), .depth(texelLatency)) funcDelay (
        .aclk(aclk),
        .rst(rst),
        .in(decConf),
        .out(exConf)
    );

    // Valid bypasses fetch and combiner, pipeLatency - 1 stages
    valueDelay #(.payload_t(logic), .depth(texelLatency + envLatency)) validDelay (
        .aclk(aclk),
        .rst(rst),
        .in(decValid),
        .out(outValid)
    );

    //////////////////////////////
    // Execute
    //////////////////////////////
    texEnv combiner (
        .aclk(aclk),
        .rst(rst),
        .func(exConf.envFunc),
        .texSrcColor(texel),
        .primaryColor(exColor),
        .envColor(exConf.envColor),
        .color(outColor)
    );

    //////////////////////////////
    // Result
    //////////////////////////////
    // Combiner output register is the pipeline output
    // Valid path must line up with the data path end to end
    validLatency: assert property (@(posedge aclk) disable iff (rst)
        outValid == $past(fragIn.valid && !rst, pipeLatency))
        else $error("fragmentPipeline: outValid out of step with fragIn.valid");

endmodule

// ==== design/fragmentShaderTop.sv ====
//////////////////////////////
// Texturing subsystem top level
// Fragment output must be taken every cycle
//////////////////////////////
`timescale 1ns/1ps

module fragmentShaderTop
    import fragmentPkg::*;
(
    input logic aclk,
    input logic rst,
    input wbReq_t wbIn,
    output wbRsp_t wbOut,
    input fragment_t fragIn,
    output logic outValid,
    output pixel_t outColor
);

    conf_t conf;
    logic texWe;
    logic [7:0] texIndex;
    pixel_t texData;
    logic [7:0] texelIndex;
    pixel_t texel;

    // Host port
    confRegs regs (
        .aclk(aclk),
        .rst(rst),
        .wbIn(wbIn),
        .wbOut(wbOut),
        .conf(conf),
        .texWe(texWe),
        .texIndex(texIndex),
        .texData(texData)
    );

    // Texel store
    textureMemory texMem (
        .aclk(aclk),
        .we(texWe),
        .wrIndex(texIndex),
        .wrData(texData),
        .rdIndex(texelIndex),
        .rdData(texel)
    );

    // Fragment path
    fragmentPipeline pipe (
        .aclk(aclk),
        .rst(rst),
        .conf(conf),
        .fragIn(fragIn),
        .texelIndex(texelIndex),
        .texel(texel),
        .outValid(outValid),
        .outColor(outColor)
    );

endmodule

// ==== sim/tbFragment.sv ====
//////////////////////////////
// Testbench for fragmentShaderTop
// Inputs change on the falling edge only
// Expected pixels come from a model of texture and config
// Texture loads never overlap fragment traffic
//////////////////////////////
`timescale 1ns/1ps

module tbFragment
    import fragmentPkg::*;
();

    localparam int last = pipeLatency - 1;
    localparam int ackTimeout = 16;

    logic aclk;
    logic rst;
    wbReq_t wbIn;
    wbRsp_t wbOut;
    fragment_t fragIn;
    logic outValid;
    pixel_t outColor;

    // Reference model state
    pixel_t modelTex [texSize*texSize];
    conf_t modelConf;
    logic expValid [pipeLatency];
    pixel_t expColor [pipeLatency];

    logic [31:0] lfsr;
    int errorCount;
    int testCount;
    int outCount;

    fragmentShaderTop DUT (
        .aclk(aclk),
        .rst(rst),
        .wbIn(wbIn),
        .wbOut(wbOut),
        .fragIn(fragIn),
        .outValid(outValid),
        .outColor(outColor)
    );

    initial
    begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    //////////////////////////////
    // Random source
    //////////////////////////////
    // Fibonacci, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randBits(int n);
        logic [31:0] value;
        logic fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    // In range, negative, top edge or most negative
    function automatic logic [15:0] pickCoord();
        logic [1:0] kind;
        logic [15:0] c;
        kind = randBits(2);
        c = 16'(randBits(15));
        if (kind == 2'd1)
            c = c | 16'h8000;
        else if (kind == 2'd2)
            c = 16'h7FFF;
        else if (kind == 2'd3)
            c = 16'h8000;
        return c;
    endfunction

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic logic [3:0] coordIndex(logic signed [15:0] c, logic clamp);
        logic signed [15:0] v;
        v = c;
        // Below zero snaps to the first texel
        if (clamp && v < 0)
            v = 16'sd0;
        // 1.0 and above would become 0x7FFF, no 1.15 code gets there
        return v[14:11];
    endfunction

    function automatic pixel_t combine(texEnvFunc_t f, pixel_t p, pixel_t t, pixel_t e);
        int pc [4];
        int tc [4];
        int ec [4];
        int oc [4];
        pc = '{p.r, p.g, p.b, p.a};
        tc = '{t.r, t.g, t.b, t.a};
        ec = '{e.r, e.g, e.b, e.a};
        oc = tc;
        // Index 3 is alpha here
        case (f)
            MODULATE:
            begin
                for (int i = 0; i < 4; i++)
                    oc[i] = (pc[i] * tc[i]) >> 8;
            end
            DECAL:
            begin
                for (int i = 0; i < 3; i++)
                    oc[i] = (tc[i] * tc[3] + pc[i] * (255 - tc[3])) >> 8;
                oc[3] = pc[3];
            end
            BLEND:
            begin
                for (int i = 0; i < 3; i++)
                    oc[i] = (pc[i] * (255 - tc[i]) + ec[i] * tc[i]) >> 8;
                oc[3] = (pc[3] * tc[3]) >> 8;
            end
            ADD:
            begin
                for (int i = 0; i < 3; i++)
                    oc[i] = (pc[i] + tc[i] > 255) ? 255 : pc[i] + tc[i];
                oc[3] = (pc[3] * tc[3]) >> 8;
            end
            default:
                ;
        endcase
        return '{r: 8'(oc[0]), g: 8'(oc[1]), b: 8'(oc[2]), a: 8'(oc[3])};
    endfunction

    function automatic pixel_t expectedPixel(fragment_t f);
        logic [3:0] sIdx;
        logic [3:0] tIdx;
        sIdx = coordIndex(f.s, modelConf.clampS);
        tIdx = coordIndex(f.t, modelConf.clampT);
        return combine(modelConf.envFunc, f.color, modelTex[{tIdx, sIdx}], modelConf.envColor);
    endfunction

    // Expected line, filled on the edge where the DUT samples the fragment
    always @(posedge aclk)
    begin
        if (rst)
        begin
            for (int i = 0; i < pipeLatency; i++)
                expValid[i] <= 1'b0;
        end
        else
        begin
            expValid[0] <= fragIn.valid;
            expColor[0] <= expectedPixel(fragIn);
            for (int i = 1; i < pipeLatency; i++)
            begin
                expValid[i] <= expValid[i-1];
                expColor[i] <= expColor[i-1];
            end
        end
    end

    always @(negedge aclk)
    begin
        if (outValid)
            outCount++;
    end

    //////////////////////////////
    // Checkers
    //////////////////////////////
    validMatch: assert property (@(posedge aclk) disable iff (rst)
        outValid == expValid[last])
    else
    begin
        errorCount++;
        $display("Fail at %0t: outValid expected %0b actual %0b", $time,
            $sampled(expValid[last]), $sampled(outValid));
    end

    colorMatch: assert property (@(posedge aclk) disable iff (rst)
        expValid[last] |-> outColor == expColor[last])
    else
    begin
        errorCount++;
        $display("Fail at %0t: outColor expected %h actual %h", $time,
            $sampled(expColor[last]), $sampled(outColor));
    end

    // One ack per access
    ackSingle: assert property (@(posedge aclk) disable iff (rst) wbOut.ack |=> !wbOut.ack)
    else
    begin
        errorCount++;
        $display("Wishbone ack stayed high for more than one cycle at %0t", $time);
    end

    task automatic checkValue(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            errorCount++;
            $display("Fail at %0t: %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic finishRun();
        $display("Tests %0d, fragments out %0d, errors %0d", testCount, outCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    task automatic endTest(string name, int startErrors);
        testCount++;
        if (errorCount == startErrors)
            $display("Test %0d %s: ok", testCount, name);
        else
            $display("Test %0d %s: %0d errors", testCount, name, errorCount - startErrors);
    endtask

    //////////////////////////////
    // Host and fragment drivers
    //////////////////////////////
    // Called on a falling edge, returns on the falling edge after ack
    task automatic wbAccess(input logic we, input logic [11:0] adr, input logic [31:0] dat,
        output logic [31:0] rdat);
        bit acked;
        acked = 1'b0;
        rdat = '0;
        wbIn = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        for (int i = 0; i < ackTimeout && !acked; i++)
        begin
            @(negedge aclk);
            acked = wbOut.ack;
        end
        wbIn = '0;
        if (acked)
            rdat = wbOut.dat;
        else
        begin
            errorCount++;
            $display("Wishbone ack never came for address %h", adr);
        end
    endtask

    task automatic wbWrite(logic [11:0] adr, logic [31:0] dat);
        logic [31:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(logic [11:0] adr, output logic [31:0] dat);
        wbAccess(1'b0, adr, '0, dat);
    endtask

    task automatic setControl(logic [2:0] func, logic cs, logic ct);
        wbWrite(adrControl, {27'd0, ct, cs, func});
        // Model follows once ack is seen
        modelConf.envFunc = texEnvFunc_t'(func);
        modelConf.clampS = cs;
        modelConf.clampT = ct;
    endtask

    task automatic setEnvColor(pixel_t c);
        wbWrite(adrEnvColor, c);
        modelConf.envColor = c;
    endtask

    task automatic sendFragment(pixel_t c, logic [15:0] s, logic [15:0] t);
        fragIn = '{valid: 1'b1, color: c, s: s, t: t};
        @(negedge aclk);
        fragIn.valid = 1'b0;
    endtask

    // Fixed by the pipeline latency
    task automatic drain();
        repeat (pipeLatency + 2) @(negedge aclk);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial
    begin
        int startErrors;
        int startOut;
        logic [31:0] data;
        logic [31:0] value;
        pixel_t c;
        logic [15:0] s;
        logic [15:0] t;
        lfsr = 32'd93464;
        errorCount = 0;
        testCount = 0;
        outCount = 0;
        modelConf = '0;
        wbIn = '0;
        fragIn = '0;
        rst = 1'b1;
        repeat (3) @(negedge aclk);
        rst = 1'b0;

        // Quiet outputs and cleared config after reset
        startErrors = errorCount;
        for (int i = 0; i < 10; i++)
        begin
            @(negedge aclk);
            checkValue("outValid", 32'd0, outValid);
            checkValue("wbOut.ack", 32'd0, wbOut.ack);
        end
        wbRead(adrControl, data);
        checkValue("control", 32'd0, data);
        endTest("reset state", startErrors);

        // Register readback, unmapped and texel reads give zero
        startErrors = errorCount;
        value = randBits(5);
        setControl(value[2:0], value[3], value[4]);
        wbRead(adrControl, data);
        checkValue("control", value, data);
        c = randBits(32);
        setEnvColor(c);
        wbRead(adrEnvColor, data);
        checkValue("envColor", c, data);
        wbWrite(12'h055, randBits(32));
        wbRead(12'h055, data);
        checkValue("unmapped", 32'd0, data);
        wbRead(adrTexBase + 12'd3, data);
        checkValue("texel readback", 32'd0, data);
        endTest("register access", startErrors);

        // Random texture, then REPLACE over every clamp mode
        startErrors = errorCount;
        for (int i = 0; i < texSize * texSize; i++)
        begin
            c = randBits(32);
            wbWrite(adrTexBase + 12'(i), c);
            modelTex[i] = c;
        end
        for (int mode = 0; mode < 4; mode++)
        begin
            setControl(REPLACE, mode[0], mode[1]);
            for (int i = 0; i < 24; i++)
            begin
                c = randBits(32);
                s = pickCoord();
                t = pickCoord();
                sendFragment(c, s, t);
            end
            drain();
        end
        endTest("coordinate modes", startErrors);

        // All five functions, ADD pushed into saturation on half the inputs
        startErrors = errorCount;
        setEnvColor(randBits(32));
        for (int f = 0; f < 5; f++)
        begin
            value = randBits(2);
            setControl(3'(f), value[0], value[1]);
            for (int i = 0; i < 16; i++)
            begin
                c = randBits(32);
                if (f == ADD && i % 2 == 0)
                    c = c | 32'h80808080;
                s = pickCoord();
                t = pickCoord();
                sendFragment(c, s, t);
            end
            drain();
        end
        endTest("environment functions", startErrors);

        // Gapped stream with a control change in flight
        startErrors = errorCount;
        setControl(MODULATE, 1'b1, 1'b1);
        startOut = outCount;
        fork
            begin : stream
                pixel_t sc;
                logic [15:0] ss;
                logic [15:0] st;
                for (int i = 0; i < 32; i++)
                begin
                    sc = randBits(32);
                    ss = pickCoord();
                    st = pickCoord();
                    sendFragment(sc, ss, st);
                    if (randBits(2) == 2'd0)
                        @(negedge aclk);
                end
            end
            begin : reconfigure
                repeat (10) @(negedge aclk);
                setControl(ADD, 1'b0, 1'b1);
            end
        join
        drain();
        checkValue("fragments out", 32'd32, outCount - startOut);
        endTest("stream and reconfigure", startErrors);

        finishRun();
    end

endmodule

// ==== tb.f ====
common/fragmentPkg.sv
design/valueDelay.sv
design/textureMemory.sv
design/confRegs.sv
texEnv/texEnv.sv
fragmentPipeline/fragmentPipeline.sv
design/fragmentShaderTop.sv
sim/tbFragment.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, verdict from sim.log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tbFragment \
    -f tb.f --Mdir obj_dir > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/VtbFragment > sim.log 2>&1

grep -q '\*\* PASS \*\*' sim.log && ! grep -q '\*\* FAIL \*\*' sim.log \
    && { echo "Simulation passed"; exit 0; } \
    || { echo "Simulation failed, see sim.log"; exit 1; }
